// File: hw/aluCore.sv
// Sixteen-function ALU with combinational result and registered status flags
`timescale 1ns/1ps

module aluCore
    import cpuTypesPkg::*;
#(
    parameter int Width = 8
) (
    input  logic             CLK,
    input  logic             arstN_i,
    input  aluOp_e           op_i,
    input  logic [Width-1:0] a_i,
    input  logic [Width-1:0] b_i,
    output logic [Width-1:0] result_o,
    output flags_t           flags_o
);

    localparam int Msb = Width - 1;

    flags_t           flagsQ;
    flags_t           flagsNext;
    logic [Width:0]   wide;                    // Extra bit holds carry or borrow
    logic [Width-1:0] result;

    always_comb begin
        wide                = '0;
        result              = a_i;
        flagsNext           = flagsQ;          // Carry and overflow hold by default
        case (op_i)
            OpPassA: result = a_i;
            OpPassB: result = b_i;
            OpNotA:  result = ~a_i;
            OpNotB:  result = ~b_i;
            OpAdd, OpAdc: begin
                wide = {1'b0, a_i} + {1'b0, b_i};
                if (op_i == OpAdc) begin
                    wide = wide + flagsQ.carry;
                end
                result = wide[Width-1:0];
                flagsNext.carry = wide[Width];
                flagsNext.overflow = (a_i[Msb] == b_i[Msb]) && (result[Msb] != a_i[Msb]);
            end
            OpSub: begin
                wide = {1'b0, a_i} - {1'b0, b_i};
                result = wide[Width-1:0];
                flagsNext.carry = wide[Width];                 // Borrow, A below B
                flagsNext.overflow = (a_i[Msb] != b_i[Msb]) && (result[Msb] != a_i[Msb]);
            end
            OpAnd:   result = a_i & b_i;
            OpOr:    result = a_i | b_i;
            OpXor:   result = a_i ^ b_i;
            OpLsl: begin
                result = {a_i[Msb-1:0], 1'b0};
                flagsNext.carry = a_i[Msb];
            end
            OpLsr: begin
                result = {1'b0, a_i[Msb:1]};
                flagsNext.carry = a_i[0];
            end
            OpAsl: begin
                result = {a_i[Msb-1:0], 1'b0};
                flagsNext.carry = a_i[Msb];
                flagsNext.overflow = a_i[Msb] ^ a_i[Msb-1];   // Sign bit changed
            end
            OpAsr:   result = {a_i[Msb], a_i[Msb:1]};         // Sign kept
            OpRol: begin
                result = {a_i[Msb-1:0], flagsQ.carry};
                flagsNext.carry = a_i[Msb];
            end
            OpRor: begin
                result = {flagsQ.carry, a_i[Msb:1]};
                flagsNext.carry = a_i[0];
            end
            default: result = a_i;
        endcase
        flagsNext.zero = (result == '0);
        flagsNext.negative = result[Msb];
    end

    always_ff @(posedge CLK or negedge arstN_i) begin
        if (!arstN_i) begin
            flagsQ <= '0;
        end else begin
            flagsQ <= flagsNext;
        end
    end

    assign result_o = result;
    assign flags_o  = flagsQ;

endmodule

// File: hw/aluSystem.sv
// Datapath top: general and address register banks, source multiplexers and ALU
`timescale 1ns/1ps

module aluSystem
    import cpuTypesPkg::*;
    import ctrlPkg::*;
(
    input  logic      CLK,
    input  logic      arstN_i,
    input  ctrlWord_t ctrl_i,
    input  word_t     extData_i,
    output word_t     aluOut_o,
    output flags_t    flags_o,
    output word_t     address_o
);

    word_t gpRdA;
    word_t gpRdB;
    word_t arRdC;
    word_t arRdD;
    word_t gpLoad;
    word_t arLoad;
    word_t opA;
    word_t aluResult;

    // General register load source
    always_comb begin
        case (ctrl_i.gpSrc)
            SrcExt:  gpLoad = extData_i;
            SrcArC:  gpLoad = arRdC;
            SrcAlu:  gpLoad = aluResult;
            default: gpLoad = extData_i;
        endcase
    end

    assign arLoad = (ctrl_i.arSrc == ArSrcAlu) ? aluResult : extData_i;
    assign opA    = ctrl_i.opASel ? arRdC : gpRdA;    // Address port C or general port A

    regBank #(
        .NumRegs (4),
        .Width   (WordWidth)
    ) gpBank (
        .CLK     (CLK),
        .arstN_i (arstN_i),
        .en_i    (ctrl_i.gp.en),
        .fun_i   (ctrl_i.gp.fun),
        .data_i  (gpLoad),
        .rdA_i   (ctrl_i.gp.rdA),
        .rdB_i   (ctrl_i.gp.rdB),
        .rdA_o   (gpRdA),
        .rdB_o   (gpRdB)
    );

    regBank #(
        .NumRegs (3),
        .Width   (WordWidth)
    ) arBank (
        .CLK     (CLK),
        .arstN_i (arstN_i),
        .en_i    (ctrl_i.ar.en),
        .fun_i   (ctrl_i.ar.fun),
        .data_i  (arLoad),
        .rdA_i   (ctrl_i.ar.rdC),
        .rdB_i   (ctrl_i.ar.rdD),
        .rdA_o   (arRdC),
        .rdB_o   (arRdD)
    );

    aluCore #(
        .Width    (WordWidth)
    ) alu (
        .CLK      (CLK),
        .arstN_i  (arstN_i),
        .op_i     (ctrl_i.aluOp),
        .a_i      (opA),
        .b_i      (gpRdB),
        .result_o (aluResult),
        .flags_o  (flags_o)
    );

    assign aluOut_o  = aluResult;
    assign address_o = arRdD;                         // Memory address from port D

endmodule

// File: hw/cpuTypesPkg.sv
// Datapath package with word and index types, register functions, ALU opcodes and flags
package cpuTypesPkg;

    localparam int WordWidth = 8;              // Datapath width in bits

    typedef logic [WordWidth-1:0] word_t;      // One data word
    typedef logic [1:0] gpIdx_t;               // General register index
    typedef logic [1:0] arIdx_t;               // 0 PC, 1 AR, 2 SP

    // Register bank function of the counter cells
    typedef enum logic [1:0] {
        FunDec  = 2'd0,
        FunInc  = 2'd1,
        FunLoad = 2'd2,
        FunClr  = 2'd3
    } regFun_e;

    typedef enum logic [3:0] {
        OpPassA = 4'h0,
        OpPassB = 4'h1,
        OpNotA  = 4'h2,
        OpNotB  = 4'h3,
        OpAdd   = 4'h4,
        OpAdc   = 4'h5,                        // Adds the stored carry
        OpSub   = 4'h6,
        OpAnd   = 4'h7,
        OpOr    = 4'h8,
        OpXor   = 4'h9,
        OpLsl   = 4'hA,
        OpLsr   = 4'hB,
        OpAsl   = 4'hC,
        OpAsr   = 4'hD,
        OpRol   = 4'hE,                        // Rotate through carry
        OpRor   = 4'hF
    } aluOp_e;

    // Zero in the top bit and overflow in the bottom bit
    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } flags_t;

endpackage

// File: hw/ctrlPkg.sv
// Control word layout for the register banks, the ALU and the source multiplexers
package ctrlPkg;

    import cpuTypesPkg::*;

    typedef struct packed {
        logic [3:0] en;                        // One enable bit per register
        regFun_e    fun;
        gpIdx_t     rdA;                       // Port A read index
        gpIdx_t     rdB;                       // Port B read index
    } gpCtrl_t;

    typedef struct packed {
        logic [2:0] en;                        // Bit 0 PC, bit 1 AR, bit 2 SP
        regFun_e    fun;
        arIdx_t     rdC;                       // Port C read index
        arIdx_t     rdD;                       // Port D drives the address output
    } arCtrl_t;

    // Load value for the general bank
    typedef enum logic [1:0] {
        SrcExt = 2'd0,
        SrcArC = 2'd1,
        SrcAlu = 2'd2
    } gpSrc_e;

    typedef enum logic {
        ArSrcExt = 1'b0,
        ArSrcAlu = 1'b1
    } arSrc_e;

    typedef struct packed {
        gpCtrl_t gp;
        arCtrl_t ar;
        aluOp_e  aluOp;
        gpSrc_e  gpSrc;
        arSrc_e  arSrc;
        logic    opASel;                       // 0 general port A, 1 address port C
    } ctrlWord_t;

endpackage

// File: hw/regBank.sv
// Register bank of up/down counters with load and clear, read through two ports
`timescale 1ns/1ps

module regBank
    import cpuTypesPkg::*;
#(
    parameter int NumRegs = 4,
    parameter int Width   = 8
) (
    input  logic                       CLK,
    input  logic                       arstN_i,
    input  logic [NumRegs-1:0]         en_i,
    input  regFun_e                    fun_i,
    input  logic [Width-1:0]           data_i,
    input  logic [$clog2(NumRegs)-1:0] rdA_i,
    input  logic [$clog2(NumRegs)-1:0] rdB_i,
    output logic [Width-1:0]           rdA_o,
    output logic [Width-1:0]           rdB_o
);

    logic [Width-1:0] regs [NumRegs];

    always_ff @(posedge CLK or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumRegs; i++) begin
                if (en_i[i]) begin                 // Disabled registers hold
                    case (fun_i)
                        FunDec:  regs[i] <= regs[i] - 1'b1;  // Wraps 0 to all ones
                        FunInc:  regs[i] <= regs[i] + 1'b1;
                        FunLoad: regs[i] <= data_i;
                        FunClr:  regs[i] <= '0;
                        default: regs[i] <= regs[i];
                    endcase
                end
            end
        end
    end

    // Read ports are independent, unused indices read as zero
    always_comb begin
        rdA_o = '0;
        rdB_o = '0;
        if (int'(rdA_i) < NumRegs) begin
            rdA_o = regs[rdA_i];
        end
        if (int'(rdB_i) < NumRegs) begin
            rdB_o = regs[rdB_i];
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module aluSystemTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/ValuSystemTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation executable returned status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation passed"; then
    exit 0
else
    exit 1
fi

// File: verification/aluSystemTb.sv
// Table-driven testbench for the datapath top with expected results per control word
`timescale 1ns/1ps

module aluSystemTb
    import cpuTypesPkg::*;
    import ctrlPkg::*;
;

    localparam int ResetCycles = 16;

    typedef struct packed {
        ctrlWord_t  ctrl;
        word_t      ext;
        word_t      expOut;
        logic [3:0] expFlags;                  // Zero, carry, negative, overflow
        word_t      expAddr;
    } row_t;

    logic      CLK;
    logic      arstN;
    ctrlWord_t ctrl;
    word_t     extData;
    word_t     aluOut;
    flags_t    flags;
    word_t     address;

    row_t      rows[$];
    ctrlWord_t pending;                        // Write fields for the next row
    word_t     pendingExt;
    int        errors;
    int        cycles;
    int        cycleLimit;

    tbClock #(
        .ResetCycles (ResetCycles)
    ) clockGen (
        .CLK     (CLK),
        .arstN_o (arstN)
    );

    aluSystem DUT (
        .CLK       (CLK),
        .arstN_i   (arstN),
        .ctrl_i    (ctrl),
        .extData_i (extData),
        .aluOut_o  (aluOut),
        .flags_o   (flags),
        .address_o (address)
    );

    task automatic gpWrite(input logic [3:0] en, input regFun_e fun, input gpSrc_e src,
                           input word_t ext);
        pending.gp.en  = en;
        pending.gp.fun = fun;
        pending.gpSrc  = src;
        pendingExt     = ext;
    endtask

    task automatic arWrite(input logic [2:0] en, input regFun_e fun, input arSrc_e src,
                           input word_t ext);
        pending.ar.en  = en;
        pending.ar.fun = fun;
        pending.arSrc  = src;
        pendingExt     = ext;
    endtask

    task automatic portC(input arIdx_t rdC, input logic useC);
        pending.ar.rdC = rdC;
        pending.opASel = useC;                 // Operand A from the address bank
    endtask

    task automatic addRow(input aluOp_e op, input gpIdx_t rdA, input gpIdx_t rdB,
                          input arIdx_t rdD, input word_t expOut,
                          input logic [3:0] expFlags, input word_t expAddr);
        row_t r;
        r.ctrl        = pending;
        r.ctrl.aluOp  = op;
        r.ctrl.gp.rdA = rdA;
        r.ctrl.gp.rdB = rdB;
        r.ctrl.ar.rdD = rdD;
        r.ext         = pendingExt;
        r.expOut      = expOut;
        r.expFlags    = expFlags;
        r.expAddr     = expAddr;
        rows.push_back(r);
        pending       = '0;
        pendingExt    = '0;
    endtask

    task automatic buildTable();
        // Reset state then loads of R0..R3 read back
        addRow(OpPassA, 0, 0, 0, 8'h00, 4'b1000, 8'h00);
        gpWrite(4'b0001, FunLoad, SrcExt, 8'h3C);
        addRow(OpPassA, 0, 0, 0, 8'h00, 4'b1000, 8'h00);
        gpWrite(4'b0010, FunLoad, SrcExt, 8'hC5);
        addRow(OpPassA, 0, 0, 0, 8'h3C, 4'b0000, 8'h00);
        gpWrite(4'b0100, FunLoad, SrcExt, 8'h80);
        addRow(OpPassB, 0, 1, 0, 8'hC5, 4'b0010, 8'h00);
        gpWrite(4'b1000, FunLoad, SrcExt, 8'hFF);
        addRow(OpPassA, 2, 0, 0, 8'h80, 4'b0010, 8'h00);
        addRow(OpPassB, 0, 3, 0, 8'hFF, 4'b0010, 8'h00);
        // Arithmetic with a second adc that picks up the stored carry
        addRow(OpAdd, 0, 1, 0, 8'h01, 4'b0100, 8'h00);
        addRow(OpAdc, 0, 1, 0, 8'h02, 4'b0100, 8'h00);
        addRow(OpSub, 0, 1, 0, 8'h77, 4'b0100, 8'h00);   // Borrow
        addRow(OpSub, 2, 0, 0, 8'h44, 4'b0001, 8'h00);   // Signed overflow
        addRow(OpAdc, 1, 0, 0, 8'h01, 4'b0100, 8'h00);
        addRow(OpAdd, 3, 3, 0, 8'hFE, 4'b0110, 8'h00);
        addRow(OpAdd, 2, 2, 0, 8'h00, 4'b1101, 8'h00);   // Leaves C and V set
        // Logic ops keep C and V
        addRow(OpPassA, 1, 0, 0, 8'hC5, 4'b0111, 8'h00);
        addRow(OpNotA, 0, 0, 0, 8'hC3, 4'b0111, 8'h00);
        addRow(OpNotB, 0, 3, 0, 8'h00, 4'b1101, 8'h00);
        addRow(OpAnd, 0, 1, 0, 8'h04, 4'b0101, 8'h00);
        addRow(OpOr, 0, 1, 0, 8'hFD, 4'b0111, 8'h00);
        addRow(OpXor, 1, 3, 0, 8'h3A, 4'b0101, 8'h00);
        addRow(OpXor, 0, 0, 0, 8'h00, 4'b1101, 8'h00);
        // Shifts and rotates
        addRow(OpLsl, 1, 0, 0, 8'h8A, 4'b0111, 8'h00);
        addRow(OpLsr, 1, 0, 0, 8'h62, 4'b0101, 8'h00);
        addRow(OpAsl, 0, 0, 0, 8'h78, 4'b0000, 8'h00);
        addRow(OpAsr, 1, 0, 0, 8'hE2, 4'b0010, 8'h00);
        addRow(OpRol, 1, 0, 0, 8'h8A, 4'b0110, 8'h00);   // Carry in 0
        addRow(OpRol, 1, 0, 0, 8'h8B, 4'b0110, 8'h00);   // Carry in 1
        addRow(OpRor, 0, 0, 0, 8'h9E, 4'b0010, 8'h00);
        addRow(OpRor, 0, 0, 0, 8'h1E, 4'b0000, 8'h00);
        addRow(OpAsl, 2, 0, 0, 8'h00, 4'b1101, 8'h00);   // Sign change sets V
        addRow(OpAsr, 2, 0, 0, 8'hC0, 4'b0111, 8'h00);
        // Address bank counting on SP then PC and AR before a full clear
        arWrite(3'b100, FunLoad, ArSrcExt, 8'h01);
        addRow(OpPassA, 0, 0, 2, 8'h3C, 4'b0101, 8'h00);
        arWrite(3'b100, FunInc, ArSrcExt, 8'h00);
        addRow(OpPassA, 0, 0, 2, 8'h3C, 4'b0101, 8'h01);
        arWrite(3'b100, FunDec, ArSrcExt, 8'h00);
        addRow(OpPassA, 0, 0, 2, 8'h3C, 4'b0101, 8'h02);
        arWrite(3'b100, FunDec, ArSrcExt, 8'h00);
        addRow(OpPassA, 0, 0, 2, 8'h3C, 4'b0101, 8'h01);
        arWrite(3'b100, FunDec, ArSrcExt, 8'h00);
        addRow(OpPassA, 0, 0, 2, 8'h3C, 4'b0101, 8'h00);   // SP wraps to FF
        arWrite(3'b001, FunLoad, ArSrcExt, 8'h12);
        addRow(OpPassA, 0, 0, 2, 8'h3C, 4'b0101, 8'hFF);
        arWrite(3'b010, FunLoad, ArSrcExt, 8'h34);
        addRow(OpPassA, 0, 0, 0, 8'h3C, 4'b0101, 8'h12);
        arWrite(3'b001, FunInc, ArSrcExt, 8'h00);
        addRow(OpPassA, 0, 0, 1, 8'h3C, 4'b0101, 8'h34);
        arWrite(3'b111, FunClr, ArSrcExt, 8'h00);
        addRow(OpPassA, 0, 0, 0, 8'h3C, 4'b0101, 8'h13);
        addRow(OpPassA, 0, 0, 2, 8'h3C, 4'b0101, 8'h00);
        // ALU results written back with AR as operand A
        gpWrite(4'b1000, FunLoad, SrcAlu, 8'h00);
        addRow(OpAdd, 0, 1, 1, 8'h01, 4'b0100, 8'h00);
        arWrite(3'b010, FunLoad, ArSrcAlu, 8'h00);
        addRow(OpXor, 0, 1, 0, 8'hF9, 4'b0110, 8'h00);     // PC cleared too
        portC(1, 1'b1);
        addRow(OpPassA, 0, 0, 1, 8'hF9, 4'b0110, 8'hF9);
        addRow(OpPassA, 3, 0, 1, 8'h01, 4'b0100, 8'hF9);
        gpWrite(4'b0100, FunLoad, SrcArC, 8'h00);
        portC(1, 1'b1);
        addRow(OpAdd, 0, 3, 1, 8'hFA, 4'b0010, 8'hF9);
        addRow(OpPassA, 2, 0, 1, 8'hF9, 4'b0010, 8'hF9);
    endtask

    task automatic applyRow(input int idx);
        row_t r;
        r = rows[idx];
        @(negedge CLK);
        ctrl    = r.ctrl;
        extData = r.ext;
        #1;                                    // Combinational outputs settled
        if (aluOut !== r.expOut) begin
            $display("Fail row %0d aluOut_o: got %h expected %h", idx, aluOut, r.expOut);
            errors++;
        end
        if (address !== r.expAddr) begin
            $display("Fail row %0d address_o: got %h expected %h", idx, address, r.expAddr);
            errors++;
        end
        @(posedge CLK);
        #1;
        if (flags !== r.expFlags) begin
            $display("Fail row %0d flags_o: got %h expected %h", idx, flags, r.expFlags);
            errors++;
        end
    endtask

    initial begin
        ctrl       = '0;
        extData    = '0;
        pending    = '0;
        pendingExt = '0;
        errors     = 0;
        buildTable();
        cycleLimit = 2 * rows.size() + ResetCycles + 20;
        wait (arstN === 1'b1);
        #1;
        if (aluOut !== 8'h00) begin
            $display("Fail after reset aluOut_o: got %h expected 00", aluOut);
            errors++;
        end
        if (flags !== 4'h0) begin
            $display("Fail after reset flags_o: got %h expected 0", flags);
            errors++;
        end
        if (address !== 8'h00) begin
            $display("Fail after reset address_o: got %h expected 00", address);
            errors++;
        end
        for (int i = 0; i < rows.size(); i++) begin
            applyRow(i);
        end
        $display("Checks done: %0d rows applied, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Run limit from the table length
    initial begin
        cycles = 0;
        wait (cycleLimit > 0);
        while (cycles < cycleLimit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: verification/tbClock.sv
// Testbench clock and reset source: 4 ns clock, reset held low for a set number of cycles
`timescale 1ns/1ps

module tbClock #(
    parameter int ResetCycles = 16
) (
    output logic CLK,
    output logic arstN_o
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;                 // 4 ns period
    end

    initial begin
        arstN_o = 1'b0;
        repeat (ResetCycles) @(posedge CLK);
        @(negedge CLK);
        arstN_o = 1'b1;                        // Released away from the rising edge
    end

endmodule

// File: verilog.f
hw/cpuTypesPkg.sv
hw/ctrlPkg.sv
hw/regBank.sv
hw/aluCore.sv
hw/aluSystem.sv
verification/tbClock.sv
verification/aluSystemTb.sv
